/* common/motors_pkg.sv */
package motors_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// move command
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// signed pixel offset per axis.
	localparam int MOVE_BITS = 8;

	typedef enum logic {
		PEN_UP   = 1'b0,
		PEN_DOWN = 1'b1
	} pen_pos_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stepper signals
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic STEP_ON  = 1'b1;
	localparam logic STEP_OFF = 1'b0;

	// dir level during a step.
	localparam logic DIR_PLUS  = 1'b1;
	localparam logic DIR_MINUS = 1'b0;

endpackage : motors_pkg

/* common/vga_pkg.sv */
package vga_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// canvas
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int CANVAS_W  = 64;
	localparam int CANVAS_H  = 48;
	localparam int CX_BITS   = 6;
	localparam int CY_BITS   = 6;
	localparam int ADDR_BITS = 12; // y * 64 + x.

	// scan counter width, covers the whole frame.
	localparam int SCAN_BITS = 11;

	typedef enum logic [1:0] {
		PIX_BLANK = 2'd0,
		PIX_INK   = 2'd1,
		PIX_TRACE = 2'd2
	} pixel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// colours
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [23:0] rgb_t; // r, g, b bytes.

	localparam rgb_t BLANK_RGB = 24'h000000;
	localparam rgb_t INK_RGB   = 24'hffffff;
	localparam rgb_t TRACE_RGB = 24'h0000ff;

endpackage : vga_pkg

/* common/step_if.sv */
`timescale 1ns/10ps

interface step_if import motors_pkg::*; ();

	logic     step_x;
	logic     dir_x;
	logic     step_y;
	logic     dir_y;
	pen_pos_t pen_down; // steady for a whole move.
	logic     clearing; // canvas wipe in progress.

	modport ctrl (
		output step_x, dir_x, step_y, dir_y, pen_down,
		input  clearing
	);

	modport tracker (
		input  step_x, dir_x, step_y, dir_y, pen_down,
		output clearing
	);

endinterface : step_if

/* motors/motors_ctrl.sv */
`timescale 1ns/10ps

module motors_ctrl import motors_pkg::*; #(
	parameter int PULSE_FACTOR = 8,
	parameter int STEP_DIV     = 2
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic signed [MOVE_BITS-1:0] move_x,
	input  logic signed [MOVE_BITS-1:0] move_y,
	input  pen_pos_t                    pen,
	input  logic                        trigger,
	output logic                        rdy,
	step_if.ctrl                        bus
);

	localparam int CNT_BITS = MOVE_BITS + $clog2(PULSE_FACTOR);
	localparam int DIV_BITS = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

	logic                 busy;
	logic                 accept;
	logic                 slot;
	logic [MOVE_BITS-1:0] mag_x;
	logic [MOVE_BITS-1:0] mag_y;
	logic [CNT_BITS-1:0]  cnt_x;
	logic [CNT_BITS-1:0]  cnt_y;
	logic [DIV_BITS-1:0]  div_cnt;

	assign rdy    = !busy && !bus.clearing;
	assign accept = trigger && rdy;
	assign slot   = busy && (div_cnt == DIV_BITS'(STEP_DIV - 1));

	// magnitude of the offsets, -128 maps to 128.
	assign mag_x = move_x[MOVE_BITS-1] ? -move_x : move_x;
	assign mag_y = move_y[MOVE_BITS-1] ? -move_y : move_y;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command latch and step slots
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			busy         <= 1'b0;
			cnt_x        <= '0;
			cnt_y        <= '0;
			div_cnt      <= '0;
			bus.step_x   <= STEP_OFF;
			bus.step_y   <= STEP_OFF;
			bus.dir_x    <= DIR_PLUS;
			bus.dir_y    <= DIR_PLUS;
			bus.pen_down <= PEN_UP;
		end else begin
			bus.step_x <= STEP_OFF;
			bus.step_y <= STEP_OFF;
			if (accept) begin
				busy         <= 1'b1;
				cnt_x        <= CNT_BITS'(mag_x) * CNT_BITS'(PULSE_FACTOR);
				cnt_y        <= CNT_BITS'(mag_y) * CNT_BITS'(PULSE_FACTOR);
				div_cnt      <= '0;
				bus.dir_x    <= move_x[MOVE_BITS-1] ? DIR_MINUS : DIR_PLUS;
				bus.dir_y    <= move_y[MOVE_BITS-1] ? DIR_MINUS : DIR_PLUS;
				bus.pen_down <= pen;
			end else if (busy) begin
				// counters hit zero in the cycle the last step is out.
				if (cnt_x == '0 && cnt_y == '0) begin
					busy <= 1'b0;
				end
				div_cnt <= slot ? '0 : div_cnt + 1'b1;
				if (slot && cnt_x != '0) begin
					bus.step_x <= STEP_ON;
					cnt_x      <= cnt_x - 1'b1;
				end
				if (slot && cnt_y != '0) begin
					bus.step_y <= STEP_ON;
					cnt_y      <= cnt_y - 1'b1;
				end
			end
		end
	end

	a_step_x_has_pulses: assert property (@(posedge clk) disable iff (reset)
		bus.step_x |-> $past(cnt_x) != '0);

endmodule : motors_ctrl

/* vga/pen_tracker.sv */
`timescale 1ns/10ps

module pen_tracker import motors_pkg::*, vga_pkg::*; #(
	parameter int PULSE_FACTOR = 8
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 trace_path,
	input  logic                 clear_screen,
	step_if.tracker              bus,
	output logic                 wr_en,
	output logic [ADDR_BITS-1:0] wr_addr,
	output pixel_t               wr_data
);

	localparam int SUB_BITS = (PULSE_FACTOR > 1) ? $clog2(PULSE_FACTOR) : 1;
	localparam int CANVAS_N = CANVAS_W * CANVAS_H;

	logic [SUB_BITS-1:0]  sub_x;
	logic [SUB_BITS-1:0]  sub_y;
	logic [CX_BITS-1:0]   pos_x;
	logic [CY_BITS-1:0]   pos_y;
	logic [CX_BITS-1:0]   nx;
	logic [CY_BITS-1:0]   ny;
	logic                 moved_x;
	logic                 moved_y;
	logic                 paint;
	logic                 ink_wr;
	logic                 trace_wr;
	logic [ADDR_BITS-1:0] target;
	logic [ADDR_BITS-1:0] clr_addr;
	logic                 ink_shadow [CANVAS_N]; // one bit per pixel, set where ink lies.

	function automatic int wrap_step(input int pos, input logic dir, input int size);
		if (dir == DIR_PLUS) begin
			return (pos == size - 1) ? 0 : pos + 1;
		end
		return (pos == 0) ? size - 1 : pos - 1;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// path and paint rule
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		moved_x = bus.step_x && (sub_x == SUB_BITS'(PULSE_FACTOR - 1));
		moved_y = bus.step_y && (sub_y == SUB_BITS'(PULSE_FACTOR - 1));
		nx = moved_x ? CX_BITS'(wrap_step(pos_x, bus.dir_x, CANVAS_W)) : pos_x;
		ny = moved_y ? CY_BITS'(wrap_step(pos_y, bus.dir_y, CANVAS_H)) : pos_y;
		// first pulse of a pixel group repaints the current pixel, so the start is drawn.
		paint = moved_x || moved_y ||
			(bus.step_x && sub_x == '0) || (bus.step_y && sub_y == '0);
		target   = {ny, nx};
		ink_wr   = paint && !bus.clearing && (bus.pen_down == PEN_DOWN);
		trace_wr = paint && !bus.clearing && (bus.pen_down == PEN_UP) &&
			trace_path && !ink_shadow[target];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sub_x        <= '0;
			sub_y        <= '0;
			pos_x        <= '0;
			pos_y        <= '0;
			bus.clearing <= 1'b0;
			clr_addr     <= '0;
			wr_en        <= 1'b0;
		end else begin
			if (bus.step_x) sub_x <= sub_x + 1'b1;
			if (bus.step_y) sub_y <= sub_y + 1'b1;
			pos_x <= nx;
			pos_y <= ny;
			wr_en <= bus.clearing || ink_wr || trace_wr;
			if (bus.clearing) begin
				clr_addr <= clr_addr + 1'b1;
				if (clr_addr == ADDR_BITS'(CANVAS_N - 1)) bus.clearing <= 1'b0;
			end else if (clear_screen) begin
				bus.clearing <= 1'b1;
				clr_addr     <= '0;
			end
		end
	end

	// write payload and ink shadow.
	always_ff @(posedge clk) begin
		if (bus.clearing) begin
			wr_addr              <= clr_addr;
			wr_data              <= PIX_BLANK;
			ink_shadow[clr_addr] <= 1'b0;
		end else begin
			wr_addr <= target;
			wr_data <= ink_wr ? PIX_INK : PIX_TRACE;
			if (ink_wr) ink_shadow[target] <= 1'b1;
		end
	end

	a_no_step_while_clearing: assert property (@(posedge clk) disable iff (reset)
		bus.clearing |-> !(bus.step_x || bus.step_y));

endmodule : pen_tracker

/* vga/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer import vga_pkg::*; (
	input  logic                 clk,
	input  logic                 wr_en,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  pixel_t               wr_data,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output pixel_t               rd_data
);

	localparam int DEPTH = CANVAS_W * CANVAS_H;

	pixel_t mem [DEPTH];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one cycle of latency.
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule : frame_buffer

/* vga/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing import vga_pkg::*; #(
	parameter int H_VISIBLE = 80,
	parameter int H_FRONT   = 4,
	parameter int H_SYNC    = 8,
	parameter int H_BACK    = 4,
	parameter int V_VISIBLE = 52,
	parameter int V_FRONT   = 2,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	output logic [SCAN_BITS-1:0] px,
	output logic [SCAN_BITS-1:0] py,
	output logic                 active,
	output logic                 h_sync,
	output logic                 v_sync
);

	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_LO = H_VISIBLE + H_FRONT;
	localparam int V_SYNC_LO = V_VISIBLE + V_FRONT;

	logic [SCAN_BITS-1:0] h_cnt;
	logic [SCAN_BITS-1:0] v_cnt;

	// reset parks on the last back porch position, first scan is (0,0).
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= SCAN_BITS'(H_TOTAL - 1);
			v_cnt <= SCAN_BITS'(V_TOTAL - 1);
		end else if (h_cnt == SCAN_BITS'(H_TOTAL - 1)) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == SCAN_BITS'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign px = h_cnt;
	assign py = v_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// window decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign active = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
	assign h_sync = !((h_cnt >= H_SYNC_LO) && (h_cnt < H_SYNC_LO + H_SYNC)); // active low.
	assign v_sync = !((v_cnt >= V_SYNC_LO) && (v_cnt < V_SYNC_LO + V_SYNC));

	a_hsync_outside_active: assert property (@(posedge clk) disable iff (reset)
		!h_sync |-> !active);

endmodule : vga_timing

/* source/plotter_top.sv */
`timescale 1ns/10ps

module plotter_top import motors_pkg::*, vga_pkg::*; #(
	parameter int PULSE_FACTOR = 8,
	parameter int STEP_DIV     = 2,
	parameter int H_VISIBLE    = 80,
	parameter int H_FRONT      = 4,
	parameter int H_SYNC       = 8,
	parameter int H_BACK       = 4,
	parameter int V_VISIBLE    = 52,
	parameter int V_FRONT      = 2,
	parameter int V_SYNC       = 2,
	parameter int V_BACK       = 2
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic signed [MOVE_BITS-1:0] move_x,
	input  logic signed [MOVE_BITS-1:0] move_y,
	input  pen_pos_t                    pen,
	input  logic                        trigger,
	input  logic                        trace_path,
	input  logic                        clear_screen,
	output logic                        rdy,
	output logic [7:0]                  r_out,
	output logic [7:0]                  g_out,
	output logic [7:0]                  b_out,
	output logic                        h_sync,
	output logic                        v_sync,
	output logic                        de
);

	logic                 wr_en;
	logic [ADDR_BITS-1:0] wr_addr;
	logic [ADDR_BITS-1:0] rd_addr;
	pixel_t               wr_data;
	pixel_t               rd_data;
	logic [SCAN_BITS-1:0] px;
	logic [SCAN_BITS-1:0] py;
	logic                 active;
	logic                 h_sync_raw;
	logic                 v_sync_raw;
	logic                 in_canvas;
	logic                 in_canvas_q;
	rgb_t                 rgb;

	step_if bus ();

	// clear wins over a trigger in the same cycle.
	motors_ctrl #(.PULSE_FACTOR(PULSE_FACTOR), .STEP_DIV(STEP_DIV)) u_motors (
		.clk(clk), .reset(reset), .move_x(move_x), .move_y(move_y), .pen(pen),
		.trigger(trigger && !clear_screen), .rdy(rdy), .bus(bus.ctrl)
	);

	pen_tracker #(.PULSE_FACTOR(PULSE_FACTOR)) u_tracker (
		.clk(clk), .reset(reset), .trace_path(trace_path),
		.clear_screen(clear_screen && rdy), .bus(bus.tracker),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	frame_buffer u_canvas (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	vga_timing #(
		.H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_timing (
		.clk(clk), .reset(reset), .px(px), .py(py), .active(active),
		.h_sync(h_sync_raw), .v_sync(v_sync_raw)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scan out
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign in_canvas = (px < CANVAS_W) && (py < CANVAS_H);
	assign rd_addr   = {py[CY_BITS-1:0], px[CX_BITS-1:0]};

	// match the canvas read latency.
	always_ff @(posedge clk) begin
		if (reset) begin
			de          <= 1'b0;
			h_sync      <= 1'b1;
			v_sync      <= 1'b1;
			in_canvas_q <= 1'b0;
		end else begin
			de          <= active;
			h_sync      <= h_sync_raw;
			v_sync      <= v_sync_raw;
			in_canvas_q <= in_canvas;
		end
	end

	always_comb begin
		rgb = BLANK_RGB;
		if (de && in_canvas_q) begin
			case (rd_data)
				PIX_INK:   rgb = INK_RGB;
				PIX_TRACE: rgb = TRACE_RGB;
				default:   rgb = BLANK_RGB;
			endcase
		end
	end

	assign r_out = rgb[23:16];
	assign g_out = rgb[15:8];
	assign b_out = rgb[7:0];

endmodule : plotter_top

/* tb/plotter_model.svh */
`ifndef PLOTTER_MODEL_SVH
`define PLOTTER_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// canvas model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

pixel_t      model_canvas [CANVAS_W * CANVAS_H];
int          model_x = 0;
int          model_y = 0;
logic [31:0] rng_state = 32'd54;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic int rand_range(input int lo, input int hi);
	rng_state = xorshift32(rng_state);
	return lo + int'(rng_state % (hi - lo + 1));
endfunction

// keeps the pen on the canvas.
function automatic int clip_offset(input int pos, input int d, input int size);
	if (pos + d < 0) return -pos;
	if (pos + d > size - 1) return size - 1 - pos;
	return d;
endfunction

task automatic model_clear();
	foreach (model_canvas[i]) model_canvas[i] = PIX_BLANK;
endtask

task automatic model_paint(input int x, input int y, input logic pen_dn, input logic trace);
	int idx;
	idx = y * CANVAS_W + x;
	if (pen_dn) begin
		model_canvas[idx] = PIX_INK;
	end else if (trace && model_canvas[idx] != PIX_INK) begin
		model_canvas[idx] = PIX_TRACE; // ink is never covered.
	end
endtask

// diagonal until the shorter axis is done, then straight.
task automatic model_move(input int dx, input int dy, input logic pen_dn, input logic trace);
	int ax;
	int ay;
	int n;
	ax = (dx < 0) ? -dx : dx;
	ay = (dy < 0) ? -dy : dy;
	n  = (ax > ay) ? ax : ay;
	if (n > 0) begin
		model_paint(model_x, model_y, pen_dn, trace); // start pixel.
		for (int i = 1; i <= n; i++) begin
			if (i <= ax) model_x += (dx < 0) ? -1 : 1;
			if (i <= ay) model_y += (dy < 0) ? -1 : 1;
			model_paint(model_x, model_y, pen_dn, trace);
		end
	end
endtask

function automatic rgb_t expected_rgb(input int col, input int row);
	if (col >= CANVAS_W || row >= CANVAS_H) return BLANK_RGB;
	case (model_canvas[row * CANVAS_W + col])
		PIX_INK:   return INK_RGB;
		PIX_TRACE: return TRACE_RGB;
		default:   return BLANK_RGB;
	endcase
endfunction

`endif

/* tb/plotter_tb.sv */
`timescale 1ns/10ps

module plotter_tb import motors_pkg::*, vga_pkg::*; ();

	localparam int PULSE_FACTOR = 8;
	localparam int STEP_DIV     = 2;
	localparam int H_VISIBLE    = 80;
	localparam int H_FRONT      = 4;
	localparam int H_SYNC       = 8;
	localparam int H_BACK       = 4;
	localparam int V_VISIBLE    = 52;
	localparam int V_FRONT      = 2;
	localparam int V_SYNC       = 2;
	localparam int V_BACK       = 2;

	localparam int N_RANDOM     = 24;
	localparam int N_MOVES      = N_RANDOM + 5;
	localparam int N_CHECKS     = 4; // frame comparisons.
	localparam int FRAME_CYCLES = (H_VISIBLE + H_FRONT + H_SYNC + H_BACK) *
		(V_VISIBLE + V_FRONT + V_SYNC + V_BACK);
	localparam int TIMEOUT_CYCLES = 2 + N_MOVES * (10 * PULSE_FACTOR * STEP_DIV + 4) +
		CANVAS_W * CANVAS_H + 4 + (2 * N_CHECKS + 1) * FRAME_CYCLES;

	logic                        clk;
	logic                        reset;
	logic signed [MOVE_BITS-1:0] move_x;
	logic signed [MOVE_BITS-1:0] move_y;
	pen_pos_t                    pen;
	logic                        trigger;
	logic                        trace_path;
	logic                        clear_screen;
	logic                        rdy;
	logic [7:0]                  r_out;
	logic [7:0]                  g_out;
	logic [7:0]                  b_out;
	logic                        h_sync;
	logic                        v_sync;
	logic                        de;

	int   err_count   = 0;
	int   check_count = 0;
	int   cycle_count = 0;
	int   frames_done = 0;
	logic want_frame  = 1'b0;
	logic checking    = 1'b0;
	int   col         = 0;
	int   row         = 0;
	int   hs_low      = 0;
	logic line_seen   = 1'b0;
	logic prev_hs     = 1'b1;
	logic prev_vs     = 1'b1;

	`include "plotter_model.svh"

	plotter_top #(
		.PULSE_FACTOR(PULSE_FACTOR), .STEP_DIV(STEP_DIV),
		.H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) dut (
		.clk(clk), .reset(reset), .move_x(move_x), .move_y(move_y), .pen(pen),
		.trigger(trigger), .trace_path(trace_path), .clear_screen(clear_screen),
		.rdy(rdy), .r_out(r_out), .g_out(g_out), .b_out(b_out),
		.h_sync(h_sync), .v_sync(v_sync), .de(de)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	task automatic finish_run(input logic timed_out);
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0 && !timed_out) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
		finish_run(1'b1);
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_channel(input string name, input int c, input int r,
		input logic [7:0] exp, input logic [7:0] got);
		check_count++;
		assert (got === exp) else begin
			$display("Error %s at (%0d,%0d): expected %h, got %h", name, c, r, exp, got);
			err_count++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_move(input int dx, input int dy, input logic pen_dn,
		input logic trace, input logic poke);
		while (!rdy) next_cycle();
		move_x     = MOVE_BITS'(dx);
		move_y     = MOVE_BITS'(dy);
		pen        = pen_pos_t'(pen_dn);
		trace_path = trace;
		trigger    = 1'b1;
		next_cycle();
		trigger = 1'b0;
		model_move(dx, dy, pen_dn, trace);
		assert (!rdy) else begin
			$display("rdy stayed high after an accepted trigger");
			err_count++;
		end
		// a trigger while busy is dropped.
		if (poke && !rdy) begin
			move_x  = MOVE_BITS'(rand_range(-10, 10));
			move_y  = MOVE_BITS'(rand_range(-10, 10));
			pen     = PEN_DOWN;
			trigger = 1'b1;
			next_cycle();
			trigger = 1'b0;
		end
		while (!rdy) next_cycle();
	endtask

	task automatic clear_canvas();
		int low_cycles;
		while (!rdy) next_cycle();
		clear_screen = 1'b1;
		next_cycle();
		clear_screen = 1'b0;
		low_cycles   = 0;
		while (!rdy) begin
			low_cycles++;
			next_cycle();
		end
		assert (low_cycles == CANVAS_W * CANVAS_H) else begin
			$display("Error rdy low time: expected %h, got %h",
				CANVAS_W * CANVAS_H, low_cycles);
			err_count++;
		end
		model_clear();
	endtask

	task automatic check_frame();
		int start;
		start      = frames_done;
		want_frame = 1'b1;
		wait (frames_done != start);
		next_cycle();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		rgb_t exp;
		if (!reset) begin
			if (de) begin
				// off-canvas area is checked in every frame.
				if (checking || col >= CANVAS_W || row >= CANVAS_H) begin
					exp = expected_rgb(col, row);
					check_channel("r_out", col, row, exp[23:16], r_out);
					check_channel("g_out", col, row, exp[15:8], g_out);
					check_channel("b_out", col, row, exp[7:0], b_out);
				end
				col++;
			end
			if (!h_sync) hs_low = prev_hs ? 1 : hs_low + 1;
			if (h_sync && !prev_hs && line_seen) begin
				assert (hs_low == H_SYNC) else begin
					$display("Error h_sync low width: expected %h, got %h", H_SYNC, hs_low);
					err_count++;
				end
			end
			if (!h_sync && prev_hs) begin
				if (line_seen && col != 0) begin
					assert (col == H_VISIBLE) else begin
						$display("Error de width on row %0d: expected %h, got %h",
							row, H_VISIBLE, col);
						err_count++;
					end
				end
				if (col != 0) row++;
				col       = 0;
				line_seen = 1'b1;
			end
			if (!v_sync && prev_vs) begin
				if (checking) begin
					assert (row == V_VISIBLE) else begin
						$display("Error de line count: expected %h, got %h", V_VISIBLE, row);
						err_count++;
					end
					checking   = 1'b0;
					want_frame = 1'b0;
					frames_done++;
				end else if (want_frame) begin
					checking = 1'b1;
				end
				row = 0;
			end
			prev_hs = h_sync;
			prev_vs = v_sync;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int   dx;
		int   dy;
		logic pen_dn;
		logic trace;
		logic poke;
		reset        = 1'b1;
		move_x       = '0;
		move_y       = '0;
		pen          = PEN_UP;
		trigger      = 1'b0;
		trace_path   = 1'b0;
		clear_screen = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (rdy === 1'b1) else begin
			$display("rdy is not high after reset");
			err_count++;
		end
		clear_canvas();
		check_frame(); // all black.

		send_move(10, 10, 1'b0, 1'b0, 1'b0); // no mark.
		send_move(8, 5, 1'b1, 1'b0, 1'b0);
		send_move(-8, -5, 1'b0, 1'b1, 1'b1); // trace crossing ink.
		send_move(-6, 9, 1'b1, 1'b0, 1'b0);
		send_move(0, -7, 1'b0, 1'b1, 1'b0);
		check_frame();

		for (int i = 0; i < N_RANDOM; i++) begin
			dx     = clip_offset(model_x, rand_range(-10, 10), CANVAS_W);
			dy     = clip_offset(model_y, rand_range(-10, 10), CANVAS_H);
			pen_dn = rand_range(0, 1) == 1;
			trace  = rand_range(0, 1) == 1;
			poke   = rand_range(0, 3) == 0;
			send_move(dx, dy, pen_dn, trace, poke);
			if (i == N_RANDOM / 2 - 1) check_frame();
		end
		check_frame();
		finish_run(1'b0);
	end

endmodule : plotter_tb

/* all.f */
+incdir+tb
common/motors_pkg.sv
common/vga_pkg.sv
common/step_if.sv
motors/motors_ctrl.sv
vga/pen_tracker.sv
vga/frame_buffer.sv
vga/vga_timing.sv
source/plotter_top.sv
tb/plotter_tb.sv

/* Bender.yml */
package:
  name: pen_plotter

sources:
  - common/motors_pkg.sv
  - common/vga_pkg.sv
  - common/step_if.sv
  - motors/motors_ctrl.sv
  - vga/pen_tracker.sv
  - vga/frame_buffer.sv
  - vga/vga_timing.sv
  - source/plotter_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/plotter_tb.sv
